// ==== common/ppu_pkg.sv ====
package ppu_pkg;

    // 640x480 at 60 Hz, counts in pixel clocks and lines
    localparam logic [9:0] H_VISIBLE = 10'd640;
    localparam logic [9:0] H_FRONT   = 10'd16;
    localparam logic [9:0] H_SYNC    = 10'd96;
    localparam logic [9:0] H_BACK    = 10'd48;
    localparam logic [9:0] V_VISIBLE = 10'd480;
    localparam logic [9:0] V_FRONT   = 10'd10;
    localparam logic [9:0] V_SYNC    = 10'd2;
    localparam logic [9:0] V_BACK    = 10'd33;

    // game area, two boards stacked vertically
    localparam logic [9:0] BOARD_X    = 10'd234;
    localparam logic [9:0] BOARD0_Y   = 10'd67;
    localparam logic [9:0] BOARD_SIZE = 10'd173;
    localparam logic [9:0] BORDER     = 10'd6;
    localparam logic [9:0] CELL       = 10'd16;
    localparam logic [9:0] GRID_N     = 10'd10;
    localparam logic [9:0] BOARD1_Y   = BOARD0_Y + BOARD_SIZE;

    // RGB332 codes
    localparam logic [7:0] COL_FRAME  = 8'h49;
    localparam logic [7:0] COL_LINE   = 8'h00;
    localparam logic [7:0] COL_WATER  = 8'h0b;
    localparam logic [7:0] COL_MISS   = 8'hdb;
    localparam logic [7:0] COL_HIT    = 8'he0;
    localparam logic [7:0] COL_BOW    = 8'hb6;
    localparam logic [7:0] COL_STRIPE = 8'hfc;

    // hull colour per ship type, entry 0 first
    localparam logic [0:3][7:0] COL_SHIP = {8'h92, 8'h6d, 8'h8c, 8'h50};

    // square state field
    localparam logic [1:0] ST_EMPTY = 2'd0;
    localparam logic [1:0] ST_MISS  = 2'd1;
    localparam logic [1:0] ST_HIT   = 2'd2;
    localparam logic [1:0] ST_SHIP  = 2'd3;

endpackage

// ==== hw/vga_timing.sv ====
module vga_timing #(
    parameter int unsigned PIPE_LEAD = 2
) (
    input  logic       vga_clk,
    input  logic       rst_n,
    input  logic [7:0] r_in,
    input  logic [7:0] g_in,
    input  logic [7:0] b_in,
    output logic [9:0] next_x,
    output logic [9:0] next_y,
    output logic       in_vblank,
    output logic [7:0] r,
    output logic [7:0] g,
    output logic [7:0] b,
    output logic       hsync,
    output logic       vsync,
    output logic       sync_n,
    output logic       blank_n,
    output logic       pix_clk
);

    localparam logic [9:0] H_TOTAL = ppu_pkg::H_VISIBLE + ppu_pkg::H_FRONT +
                                     ppu_pkg::H_SYNC + ppu_pkg::H_BACK;
    localparam logic [9:0] V_TOTAL = ppu_pkg::V_VISIBLE + ppu_pkg::V_FRONT +
                                     ppu_pkg::V_SYNC + ppu_pkg::V_BACK;
    localparam logic [9:0] HS_START = ppu_pkg::H_VISIBLE + ppu_pkg::H_FRONT;
    localparam logic [9:0] VS_START = ppu_pkg::V_VISIBLE + ppu_pkg::V_FRONT;

    logic [9:0]  h_cnt;
    logic [9:0]  v_cnt;
    logic [10:0] h_ahead;
    logic        hsync_d;
    logic        vsync_d;
    logic        visible;

    // beam position, visible area first in both directions
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_TOTAL - 10'd1) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_TOTAL - 10'd1) ? 10'd0 : v_cnt + 10'd1;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    // position PIPE_LEAD clocks ahead, wraps into next line and frame
    always_comb begin
        h_ahead = {1'b0, h_cnt} + 11'(PIPE_LEAD);
        if (h_ahead >= {1'b0, H_TOTAL}) begin
            next_x = 10'(h_ahead - {1'b0, H_TOTAL});
            next_y = (v_cnt == V_TOTAL - 10'd1) ? 10'd0 : v_cnt + 10'd1;
        end else begin
            next_x = h_ahead[9:0];
            next_y = v_cnt;
        end
    end

    // taken from the look-ahead line so the store is frozen
    // before the first pixel of a frame is fetched
    assign in_vblank = (next_y >= ppu_pkg::V_VISIBLE);

    assign hsync_d = !((h_cnt >= HS_START) && (h_cnt < HS_START + ppu_pkg::H_SYNC));
    assign vsync_d = !((v_cnt >= VS_START) && (v_cnt < VS_START + ppu_pkg::V_SYNC));
    assign visible = (h_cnt < ppu_pkg::H_VISIBLE) && (v_cnt < ppu_pkg::V_VISIBLE);

    // one register stage; colour from the pipe lands with the same beam position
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            blank_n <= 1'b0;
            r       <= '0;
            g       <= '0;
            b       <= '0;
        end else begin
            hsync   <= hsync_d;
            vsync   <= vsync_d;
            blank_n <= visible;
            r       <= visible ? r_in : 8'h00;
            g       <= visible ? g_in : 8'h00;
            b       <= visible ? b_in : 8'h00;
        end
    end

    // DAC side
    assign sync_n  = 1'b1;
    assign pix_clk = vga_clk;

    // beam and look-ahead position both stay inside one frame
    a_cnt_range : assert property (@(posedge vga_clk) disable iff (!rst_n)
        (h_cnt < H_TOTAL) && (v_cnt < V_TOTAL) &&
        (next_x < H_TOTAL) && (next_y < V_TOTAL));

endmodule

// ==== ppu/square_store.sv ====
module square_store (
    input  logic       vga_clk,
    input  logic       rst_n,
    input  logic       upd_valid,
    output logic       upd_ready,
    input  logic       upd_board,
    input  logic [6:0] upd_square,
    input  logic [1:0] upd_state,
    input  logic [1:0] upd_ship_type,
    input  logic [2:0] upd_ship_section,
    input  logic       upd_vert,
    input  logic       upd_sel,
    input  logic       in_vblank,
    input  logic       rd_board,
    input  logic [6:0] rd_square,
    output logic [1:0] rd_state,
    output logic [1:0] rd_ship_type,
    output logic [2:0] rd_ship_section,
    output logic       rd_vert,
    output logic       rd_sel
);

    // record layout {state, type, section, vert, sel}
    logic [8:0] mem [0:1][0:99];
    logic [8:0] rec;

    // host is held off for the whole visible part of a frame
    assign upd_ready = in_vblank;

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int bd = 0; bd < 2; bd++) begin
                for (int sq = 0; sq < 100; sq++) begin
                    mem[bd][sq] <= '0;
                end
            end
        end else if (upd_valid && upd_ready) begin
            mem[upd_board][upd_square] <= {upd_state, upd_ship_type, upd_ship_section,
                                           upd_vert, upd_sel};
        end
    end

    // no read latency, the locator already holds the index in a register
    assign rec             = mem[rd_board][rd_square];
    assign rd_state        = rec[8:7];
    assign rd_ship_type    = rec[6:5];
    assign rd_ship_section = rec[4:2];
    assign rd_vert         = rec[1];
    assign rd_sel          = rec[0];

    a_upd_range : assert property (@(posedge vga_clk) disable iff (!rst_n)
        (upd_valid && upd_ready) |->
            ({3'b000, upd_square} < ppu_pkg::GRID_N * ppu_pkg::GRID_N));

endmodule

// ==== ppu/tile_locator.sv ====
module tile_locator (
    input  logic       vga_clk,
    input  logic       rst_n,
    input  logic [9:0] next_x,
    input  logic [9:0] next_y,
    output logic       in_area,
    output logic       on_grid,
    output logic       board_sel,
    output logic [6:0] square_idx,
    output logic [3:0] off_x,
    output logic [3:0] off_y
);

    localparam logic [9:0] GRID_W  = ppu_pkg::GRID_N * ppu_pkg::CELL;
    localparam logic [9:0] GRID_X  = ppu_pkg::BOARD_X + ppu_pkg::BORDER;
    localparam logic [9:0] GRID0_Y = ppu_pkg::BOARD0_Y + ppu_pkg::BORDER;
    localparam logic [9:0] GRID1_Y = ppu_pkg::BOARD1_Y + ppu_pkg::BORDER;
    localparam logic [9:0] AREA_X1 = ppu_pkg::BOARD_X + ppu_pkg::BOARD_SIZE;
    localparam logic [9:0] AREA_Y1 = ppu_pkg::BOARD1_Y + ppu_pkg::BOARD_SIZE;

    logic       area_d;
    logic       in_gx;
    logic       on0;
    logic       on1;
    logic [9:0] dx;
    logic [9:0] dy0;
    logic [9:0] dy1;
    logic [9:0] dy;
    logic [3:0] col;
    logic [3:0] row;
    logic [6:0] idx_d;

    // whole game rectangle, both boards with frames
    assign area_d = (next_x >= ppu_pkg::BOARD_X) && (next_x < AREA_X1) &&
                    (next_y >= ppu_pkg::BOARD0_Y) && (next_y < AREA_Y1);

    assign in_gx = (next_x >= GRID_X) && (next_x < GRID_X + GRID_W);
    assign on0   = in_gx && (next_y >= GRID0_Y) && (next_y < GRID0_Y + GRID_W);
    assign on1   = in_gx && (next_y >= GRID1_Y) && (next_y < GRID1_Y + GRID_W);

    assign dx  = next_x - GRID_X;
    assign dy0 = next_y - GRID0_Y;
    assign dy1 = next_y - GRID1_Y;
    assign dy  = on1 ? dy1 : dy0;

    // 16 pixel squares, so the high nibble is the square and the low one the offset
    assign col   = dx[7:4];
    assign row   = dy[7:4];
    assign idx_d = 7'(row) * 7'(ppu_pkg::GRID_N) + 7'(col);

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_area    <= 1'b0;
            on_grid    <= 1'b0;
            board_sel  <= 1'b0;
            square_idx <= '0;
            off_x      <= '0;
            off_y      <= '0;
        end else begin
            in_area <= area_d;
            if (on0 || on1) begin
                on_grid    <= 1'b1;
                board_sel  <= on1;
                square_idx <= idx_d;
                off_x      <= dx[3:0];
                off_y      <= dy[3:0];
            end else begin
                // keeps the store read inside its range
                on_grid    <= 1'b0;
                board_sel  <= 1'b0;
                square_idx <= '0;
                off_x      <= '0;
                off_y      <= '0;
            end
        end
    end

endmodule

// ==== ppu/sprite_gen.sv ====
module sprite_gen (
    input  logic       vga_clk,
    input  logic       rst_n,
    input  logic       in_area,
    input  logic       on_grid,
    input  logic [3:0] off_x,
    input  logic [3:0] off_y,
    input  logic [1:0] state,
    input  logic [1:0] ship_type,
    input  logic [2:0] ship_section,
    input  logic       vert,
    input  logic       sel,
    output logic [7:0] code,
    output logic       sel_q,
    output logic       area_q
);

    logic [7:0] code_d;
    logic       stripe;
    logic       bow;
    logic       centre;

    // stripe runs along the ship, bow cap sits at its leading end
    assign stripe = vert ? (off_x == 4'd7 || off_x == 4'd8) :
                           (off_y == 4'd7 || off_y == 4'd8);
    assign bow    = (ship_section == 3'd0) &&
                    (vert ? (off_y == 4'd1 || off_y == 4'd2) :
                            (off_x == 4'd1 || off_x == 4'd2));
    assign centre = (off_x >= 4'd6) && (off_x <= 4'd9) &&
                    (off_y >= 4'd6) && (off_y <= 4'd9);

    // first matching rule wins
    always_comb begin
        if (!on_grid) begin
            code_d = ppu_pkg::COL_FRAME;
        end else if (off_x == 4'd0 || off_y == 4'd0) begin
            code_d = ppu_pkg::COL_LINE;
        end else if (state == ppu_pkg::ST_SHIP) begin
            if (stripe) begin
                code_d = ppu_pkg::COL_STRIPE;
            end else if (bow) begin
                code_d = ppu_pkg::COL_BOW;
            end else begin
                code_d = ppu_pkg::COL_SHIP[ship_type];
            end
        end else if (state == ppu_pkg::ST_HIT && centre) begin
            code_d = ppu_pkg::COL_HIT;
        end else if (state == ppu_pkg::ST_MISS && centre) begin
            code_d = ppu_pkg::COL_MISS;
        end else begin
            code_d = ppu_pkg::COL_WATER;
        end
    end

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            code   <= '0;
            sel_q  <= 1'b0;
            area_q <= 1'b0;
        end else begin
            code   <= code_d;
            // the frame never shows a selection
            sel_q  <= on_grid && sel;
            area_q <= in_area;
        end
    end

endmodule

// ==== ppu/pixel_mux.sv ====
module pixel_mux (
    input  logic [7:0] code,
    input  logic       sel_q,
    input  logic       area_q,
    output logic [7:0] r_in,
    output logic [7:0] g_in,
    output logic [7:0] b_in
);

    logic [7:0] pix;

    // selected square drawn as its colour complement
    assign pix = sel_q ? ~code : code;

    // RGB332 to the top bits of each 8 bit channel, white around the game
    assign r_in = area_q ? {pix[7:5], 5'b0} : 8'hff;
    assign g_in = area_q ? {pix[4:2], 5'b0} : 8'hff;
    assign b_in = area_q ? {pix[1:0], 6'b0} : 8'hff;

endmodule

// ==== ppu/ppu.sv ====
module ppu #(
    parameter int unsigned PIPE_LEAD = 2
) (
    input  logic       vga_clk,
    input  logic       rst_n,
    input  logic       upd_valid,
    output logic       upd_ready,
    input  logic       upd_board,
    input  logic [6:0] upd_square,
    input  logic [1:0] upd_state,
    input  logic [1:0] upd_ship_type,
    input  logic [2:0] upd_ship_section,
    input  logic       upd_vert,
    input  logic       upd_sel,
    output logic [7:0] r,
    output logic [7:0] g,
    output logic [7:0] b,
    output logic       vga_hs,
    output logic       vga_vs,
    output logic       vga_sync_n,
    output logic       vga_blank_n,
    output logic       vga_clk_out
);

    logic [9:0] next_x;
    logic [9:0] next_y;
    logic       in_vblank;
    logic [7:0] r_in;
    logic [7:0] g_in;
    logic [7:0] b_in;

    // locator stage
    logic       in_area;
    logic       on_grid;
    logic       board_sel;
    logic [6:0] square_idx;
    logic [3:0] off_x;
    logic [3:0] off_y;

    // record of the current square
    logic [1:0] rd_state;
    logic [1:0] rd_ship_type;
    logic [2:0] rd_ship_section;
    logic       rd_vert;
    logic       rd_sel;

    // sprite stage
    logic [7:0] code;
    logic       sel_q;
    logic       area_q;

    vga_timing #(
        .PIPE_LEAD (PIPE_LEAD)
    ) i_vga_timing (
        .vga_clk   (vga_clk),
        .rst_n     (rst_n),
        .r_in      (r_in),
        .g_in      (g_in),
        .b_in      (b_in),
        .next_x    (next_x),
        .next_y    (next_y),
        .in_vblank (in_vblank),
        .r         (r),
        .g         (g),
        .b         (b),
        .hsync     (vga_hs),
        .vsync     (vga_vs),
        .sync_n    (vga_sync_n),
        .blank_n   (vga_blank_n),
        .pix_clk   (vga_clk_out)
    );

    tile_locator i_tile_locator (
        .vga_clk    (vga_clk),
        .rst_n      (rst_n),
        .next_x     (next_x),
        .next_y     (next_y),
        .in_area    (in_area),
        .on_grid    (on_grid),
        .board_sel  (board_sel),
        .square_idx (square_idx),
        .off_x      (off_x),
        .off_y      (off_y)
    );

    square_store i_square_store (
        .vga_clk          (vga_clk),
        .rst_n            (rst_n),
        .upd_valid        (upd_valid),
        .upd_ready        (upd_ready),
        .upd_board        (upd_board),
        .upd_square       (upd_square),
        .upd_state        (upd_state),
        .upd_ship_type    (upd_ship_type),
        .upd_ship_section (upd_ship_section),
        .upd_vert         (upd_vert),
        .upd_sel          (upd_sel),
        .in_vblank        (in_vblank),
        .rd_board         (board_sel),
        .rd_square        (square_idx),
        .rd_state         (rd_state),
        .rd_ship_type     (rd_ship_type),
        .rd_ship_section  (rd_ship_section),
        .rd_vert          (rd_vert),
        .rd_sel           (rd_sel)
    );

    sprite_gen i_sprite_gen (
        .vga_clk      (vga_clk),
        .rst_n        (rst_n),
        .in_area      (in_area),
        .on_grid      (on_grid),
        .off_x        (off_x),
        .off_y        (off_y),
        .state        (rd_state),
        .ship_type    (rd_ship_type),
        .ship_section (rd_ship_section),
        .vert         (rd_vert),
        .sel          (rd_sel),
        .code         (code),
        .sel_q        (sel_q),
        .area_q       (area_q)
    );

    pixel_mux i_pixel_mux (
        .code   (code),
        .sel_q  (sel_q),
        .area_q (area_q),
        .r_in   (r_in),
        .g_in   (g_in),
        .b_in   (b_in)
    );

endmodule

// ==== bench/ppu_ref.svh ====
`ifndef PPU_REF_SVH
`define PPU_REF_SVH

// grid corners in screen pixels
localparam int REF_AREA_X0 = int'(ppu_pkg::BOARD_X);
localparam int REF_AREA_Y0 = int'(ppu_pkg::BOARD0_Y);
localparam int REF_SIZE    = int'(ppu_pkg::BOARD_SIZE);
localparam int REF_GRID_X  = int'(ppu_pkg::BOARD_X) + int'(ppu_pkg::BORDER);
localparam int REF_GRID0_Y = int'(ppu_pkg::BOARD0_Y) + int'(ppu_pkg::BORDER);
localparam int REF_GRID1_Y = int'(ppu_pkg::BOARD1_Y) + int'(ppu_pkg::BORDER);
localparam int REF_CELL    = int'(ppu_pkg::CELL);
localparam int REF_GRID_W  = int'(ppu_pkg::GRID_N) * int'(ppu_pkg::CELL);

// shadow boards, {state, type, section, vert, sel} per square
logic [8:0] pend_rec  [0:1][0:99];
logic [8:0] shown_rec [0:1][0:99];

function automatic void model_clear();
    pend_rec  = '{default: '0};
    shown_rec = '{default: '0};
endfunction

function automatic void model_accept(logic board, logic [6:0] square, logic [8:0] rec);
    pend_rec[board][square] = rec;
endfunction

// accepted writes become visible as a new frame begins
function automatic void model_frame_start();
    shown_rec = pend_rec;
endfunction

function automatic logic [7:0] expected_code(int x, int y);
    int         gx;
    int         gy;
    int         ox;
    int         oy;
    logic       bd;
    logic [8:0] rec;
    logic [7:0] c;
    gx = x - REF_GRID_X;
    bd = (y >= REF_GRID1_Y - int'(ppu_pkg::BORDER));
    gy = bd ? y - REF_GRID1_Y : y - REF_GRID0_Y;
    if (gx < 0 || gx >= REF_GRID_W || gy < 0 || gy >= REF_GRID_W) begin
        return ppu_pkg::COL_FRAME;
    end
    ox  = gx % REF_CELL;
    oy  = gy % REF_CELL;
    rec = shown_rec[bd][(gy / REF_CELL) * 10 + gx / REF_CELL];
    if (ox == 0 || oy == 0) begin
        c = ppu_pkg::COL_LINE;
    end else if (rec[8:7] == ppu_pkg::ST_SHIP) begin
        // stripe along the hull, then the bow cap of section 0
        if ((rec[1] && (ox == 7 || ox == 8)) || (!rec[1] && (oy == 7 || oy == 8))) begin
            c = ppu_pkg::COL_STRIPE;
        end else if (rec[4:2] == 3'd0 &&
                     ((rec[1] && (oy == 1 || oy == 2)) || (!rec[1] && (ox == 1 || ox == 2)))) begin
            c = ppu_pkg::COL_BOW;
        end else begin
            c = ppu_pkg::COL_SHIP[rec[6:5]];
        end
    end else if (rec[8:7] != ppu_pkg::ST_EMPTY && ox >= 6 && ox <= 9 && oy >= 6 && oy <= 9) begin
        c = (rec[8:7] == ppu_pkg::ST_HIT) ? ppu_pkg::COL_HIT : ppu_pkg::COL_MISS;
    end else begin
        c = ppu_pkg::COL_WATER;
    end
    return rec[0] ? ~c : c;
endfunction

function automatic logic [23:0] expected_rgb(int x, int y);
    logic [7:0] c;
    if (x < REF_AREA_X0 || x >= REF_AREA_X0 + REF_SIZE ||
        y < REF_AREA_Y0 || y >= REF_AREA_Y0 + 2 * REF_SIZE) begin
        return 24'hffffff;
    end
    c = expected_code(x, y);
    return {c[7:5], 5'b0, c[4:2], 5'b0, c[1:0], 6'b0};
endfunction

`endif

// ==== bench/ppu_tb.sv ====
module ppu_tb;

    localparam int FRAME_CYCLES   = 800 * 525;
    // reset, a partial first frame and three checked frames fit well inside
    localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES + 20000;
    localparam int SHIP_WRITES    = 24;

    logic       vga_clk;
    logic       rst_n;
    logic       upd_valid;
    logic       upd_ready;
    logic       upd_board;
    logic [6:0] upd_square;
    logic [1:0] upd_state;
    logic [1:0] upd_ship_type;
    logic [2:0] upd_ship_section;
    logic       upd_vert;
    logic       upd_sel;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    logic       vga_hs;
    logic       vga_vs;
    logic       vga_sync_n;
    logic       vga_blank_n;
    logic       vga_clk_out;

    int          mismatches;
    int          sync_errors;
    int          protocol_errors;
    int          timeouts;
    int          cycles;
    int          vs_falls;
    int          px;
    int          py;
    int          vis_count;
    int          hs_low;
    int          hs_pulses;
    int          vs_low;
    int          stall;
    logic        vs_prev;
    logic        frame_started;
    logic        first_pix;
    logic [23:0] exp_rgb;
    logic [31:0] lcg_state;
    logic [31:0] rnd;
    logic        ship_board [0:3];
    logic [6:0]  ship_square [0:3];
    string       test_name;

    `include "ppu_ref.svh"

    ppu #(
        .PIPE_LEAD (2)
    ) i_ppu (
        .vga_clk          (vga_clk),
        .rst_n            (rst_n),
        .upd_valid        (upd_valid),
        .upd_ready        (upd_ready),
        .upd_board        (upd_board),
        .upd_square       (upd_square),
        .upd_state        (upd_state),
        .upd_ship_type    (upd_ship_type),
        .upd_ship_section (upd_ship_section),
        .upd_vert         (upd_vert),
        .upd_sel          (upd_sel),
        .r                (r),
        .g                (g),
        .b                (b),
        .vga_hs           (vga_hs),
        .vga_vs           (vga_vs),
        .vga_sync_n       (vga_sync_n),
        .vga_blank_n      (vga_blank_n),
        .vga_clk_out      (vga_clk_out)
    );

    always #2 vga_clk = ~vga_clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'b0, lcg_state[30:16]};
    endfunction

    // holds the record until the store takes it, returns the stalled cycles
    task automatic send_update(input logic bd, input logic [6:0] sq, input logic [1:0] st,
                               input logic [1:0] ty, input logic [2:0] sec,
                               input logic vt, input logic sl, output int stalled);
        stalled = 0;
        @(negedge vga_clk);
        upd_board        = bd;
        upd_square       = sq;
        upd_state        = st;
        upd_ship_type    = ty;
        upd_ship_section = sec;
        upd_vert         = vt;
        upd_sel          = sl;
        upd_valid        = 1'b1;
        while (!upd_ready) begin
            stalled++;
            @(negedge vga_clk);
        end
        model_accept(bd, sq, {st, ty, sec, vt, sl});
        @(negedge vga_clk);
        upd_valid = 1'b0;
    endtask

    // same record again with the selection bit set
    task automatic select_square(input logic bd, input logic [6:0] sq);
        logic [8:0] old;
        int         stalled;
        old = pend_rec[bd][sq];
        send_update(bd, sq, old[8:7], old[6:5], old[4:2], old[1], 1'b1, stalled);
    endtask

    task automatic wait_vsync_falls(input int n);
        while (vs_falls < n) begin
            @(negedge vga_clk);
        end
    endtask

    task automatic end_run();
        int total;
        total = mismatches + sync_errors + protocol_errors + timeouts;
        $display("errors: %0d total, %0d pixel, %0d sync, %0d protocol, %0d timeout",
                 total, mismatches, sync_errors, protocol_errors, timeouts);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // DAC outputs, looked at between clock edges
    always @(vga_clk) begin
        #1;
        assert (vga_sync_n === 1'b1 && vga_clk_out === vga_clk) else begin
            sync_errors++;
            $display("error: vga_sync_n is not high or vga_clk_out does not follow vga_clk");
        end
    end

    // beam tracking and checks, outputs are settled at the falling edge
    always @(negedge vga_clk) begin
        if (rst_n) begin
            assert (!(vga_blank_n && upd_ready)) else begin
                protocol_errors++;
                $display("error: upd_ready is high while a visible pixel is drawn");
            end
            if (!vga_hs) begin
                hs_low++;
            end else if (hs_low != 0) begin
                assert (hs_low == 96) else begin
                    sync_errors++;
                    $display("Mismatch sync_timing hsync low cycles: expected 96, actual %0d",
                             hs_low);
                end
                hs_low = 0;
                hs_pulses++;
            end
            if (vs_prev && !vga_vs) begin
                if (frame_started) begin
                    assert (vis_count == 640 * 480) else begin
                        sync_errors++;
                        $display("Mismatch sync_timing visible cycles: expected %0d, actual %0d",
                                 640 * 480, vis_count);
                    end
                    assert (hs_pulses == 525) else begin
                        sync_errors++;
                        $display("Mismatch sync_timing hsync pulses: expected 525, actual %0d",
                                 hs_pulses);
                    end
                end
                vs_falls++;
                frame_started = 1'b1;
                first_pix     = 1'b1;
                vis_count     = 0;
                hs_pulses     = 0;
                px            = 0;
                py            = 0;
            end
            if (!vga_vs) begin
                vs_low++;
            end else if (vs_low != 0) begin
                assert (vs_low == 2 * 800) else begin
                    sync_errors++;
                    $display("Mismatch sync_timing vsync low cycles: expected 1600, actual %0d",
                             vs_low);
                end
                vs_low = 0;
            end
            vs_prev = vga_vs;
            if (vga_blank_n && frame_started) begin
                if (first_pix) begin
                    model_frame_start();
                    first_pix = 1'b0;
                end
                exp_rgb = expected_rgb(px, py);
                assert ({r, g, b} == exp_rgb) else begin
                    mismatches++;
                    $display("Mismatch %s at (%0d,%0d): expected %06h, actual %06h",
                             test_name, px, py, exp_rgb, {r, g, b});
                end
                vis_count++;
                px++;
                if (px == 640) begin
                    px = 0;
                    py++;
                end
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge vga_clk);
            cycles++;
        end
        timeouts++;
        $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end_run();
    end

    initial begin
        vga_clk          = 1'b0;
        rst_n            = 1'b0;
        upd_valid        = 1'b0;
        upd_board        = 1'b0;
        upd_square       = '0;
        upd_state        = '0;
        upd_ship_type    = '0;
        upd_ship_section = '0;
        upd_vert         = 1'b0;
        upd_sel          = 1'b0;
        mismatches       = 0;
        sync_errors      = 0;
        protocol_errors  = 0;
        timeouts         = 0;
        vs_falls         = 0;
        px               = 0;
        py               = 0;
        vis_count        = 0;
        hs_low           = 0;
        hs_pulses        = 0;
        vs_low           = 0;
        vs_prev          = 1'b1;
        frame_started    = 1'b0;
        first_pix        = 1'b0;
        lcg_state        = 32'd36;
        test_name        = "reset";
        model_clear();

        repeat (16) @(posedge vga_clk);
        @(negedge vga_clk);
        assert (vga_hs && vga_vs && !vga_blank_n && {r, g, b} == 24'h0 && !upd_ready) else begin
            protocol_errors++;
            $display("error: outputs are not in their reset state while reset is held");
        end
        rst_n = 1'b1;

        // first checked frame still shows the cleared boards
        test_name = "empty_boards";
        wait_vsync_falls(1);
        while (!vga_blank_n) begin
            @(negedge vga_clk);
        end

        test_name = "marker_stall";
        send_update(1'b0, 7'd23, ppu_pkg::ST_MISS, 2'd0, 3'd0, 1'b0, 1'b0, stall);
        assert (stall > 0) else begin
            protocol_errors++;
            $display("error: a write issued in the visible area was taken without a stall");
        end
        send_update(1'b1, 7'd77, ppu_pkg::ST_HIT, 2'd0, 3'd0, 1'b0, 1'b0, stall);

        test_name = "random_ships";
        for (int i = 0; i < SHIP_WRITES; i++) begin
            rnd = next_random();
            upd_board = rnd[0];
            rnd = next_random();
            upd_square = 7'(rnd % 100);
            rnd = next_random();
            if (i < 4) begin
                ship_board[i]  = upd_board;
                ship_square[i] = upd_square;
            end
            send_update(upd_board, upd_square, ppu_pkg::ST_SHIP, 2'(i % 4),
                        (i % 3 == 0) ? 3'd0 : 3'(rnd % 5 + 1), 1'((i / 4) % 2), 1'b0, stall);
        end

        wait_vsync_falls(2);
        while (!vga_blank_n) begin
            @(negedge vga_clk);
        end
        test_name = "select_invert";
        select_square(1'b0, 7'd23);
        select_square(1'b1, 7'd77);
        select_square(1'b0, 7'd0);
        select_square(1'b1, 7'd99);
        for (int i = 0; i < 4; i++) begin
            select_square(ship_board[i], ship_square[i]);
        end

        // frame three carries the selections to the screen
        wait_vsync_falls(4);
        end_run();
    end

endmodule

// ==== list.f ====
common/ppu_pkg.sv
hw/vga_timing.sv
ppu/square_store.sv
ppu/tile_locator.sv
ppu/sprite_gen.sv
ppu/pixel_mux.sv
ppu/ppu.sv
+incdir+bench
bench/ppu_tb.sv

// ==== Makefile ====
# Verilator build of the PPU testbench

VERILATOR ?= verilator
TOP       ?= ppu_tb
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST OK

SRCS := $(shell grep -v '^+' $(FLIST)) bench/ppu_ref.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
